/* rf_trace.f */
hw/rf_trace_pkg.sv
hw/rf_write_if.sv
hw/wb_lane_merge.sv
hw/rfwrite_queue.sv
hw/trace_packer.sv
hw/rf_trace_top.sv
tb/rf_trace_tb.sv

/* Bender.yml */
package:
  name: rf_trace

sources:
  # package and interface first, blocks bottom-up
  - hw/rf_trace_pkg.sv
  - hw/rf_write_if.sv
  - hw/wb_lane_merge.sv
  - hw/rfwrite_queue.sv
  - hw/trace_packer.sv
  - hw/rf_trace_top.sv

  - target: test
    files:
      - tb/rf_trace_tb.sv

/* tb/rf_trace_vectors.txt */
# rep wen1 wa1 wd1 pc1 wen0 wa0 wd0 pc0 recs  (rep and recs decimal, the rest hex)
# each line is driven rep cycles, wd steps by 1 and pc by 8 per cycle, recs = records per cycle
3   0 00 00000000 00000000 0 00 00000000 00000000 0
1   1 05 cafe0005 00400000 0 00 00000000 00000000 1
5   0 00 00000000 00000000 0 00 00000000 00000000 0
1   0 00 00000000 00000000 1 07 beef0007 00400008 1
5   0 00 00000000 00000000 0 00 00000000 00000000 0
# both lanes in one cycle
1   1 03 11110003 00400010 1 04 22220004 00400014 2
4   0 00 00000000 00000000 0 00 00000000 00000000 0
# r0 writes and disabled lanes give nothing
1   1 00 dead0000 00400020 1 09 33330009 00400024 1
1   1 0a 4444000a 00400028 1 00 dead0001 0040002c 1
1   1 00 dead0002 00400030 1 00 dead0003 00400034 0
1   0 0b 5555000b 00400038 0 0c 6666000c 0040003c 0
4   0 00 00000000 00000000 0 00 00000000 00000000 0
# dual burst, then drain
30  1 11 a0000000 00401000 1 12 b0000000 00401004 2
40  0 00 00000000 00000000 0 00 00000000 00000000 0
# long single-write stream wraps the queue pointers
200 1 1f c0000000 00402000 0 00 00000000 00000000 1
50  1 08 d0000000 00403000 1 00 e0000000 00403004 1
25  1 14 f0000000 00404000 1 15 f1000000 00404004 2
30  0 00 00000000 00000000 0 00 00000000 00000000 0
100 0 00 00000000 00000000 1 02 12340000 00405000 1
5   0 00 00000000 00000000 0 00 00000000 00000000 0
1   1 1e 9abc001e 00406000 0 00 00000000 00000000 1
5   0 00 00000000 00000000 0 00 00000000 00000000 0

/* tb/rf_trace_tb.sv */
module rf_trace_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        int                      rep;
        logic                    wen1;
        rf_trace_pkg::reg_addr_t wa1;
        rf_trace_pkg::word_t     wd1;
        rf_trace_pkg::word_t     pc1;
        logic                    wen0;
        rf_trace_pkg::reg_addr_t wa0;
        rf_trace_pkg::word_t     wd0;
        rf_trace_pkg::word_t     pc0;
    } vec_t;

    typedef struct {
        rf_trace_pkg::reg_addr_t wa;
        rf_trace_pkg::word_t     wd;
        rf_trace_pkg::word_t     pc;
        int                      drive_cyc;
        bit                      exact;   // lone write into an empty pipe
    } rec_t;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    wb1_wen;
    logic                    wb0_wen;
    rf_trace_pkg::reg_addr_t wb1_wa;
    rf_trace_pkg::reg_addr_t wb0_wa;
    rf_trace_pkg::word_t     wb1_wd;
    rf_trace_pkg::word_t     wb0_wd;
    rf_trace_pkg::word_t     wb1_pc;
    rf_trace_pkg::word_t     wb0_pc;
    logic                    trace_valid;
    rf_trace_pkg::reg_addr_t trace_reg;
    rf_trace_pkg::word_t     trace_data;
    rf_trace_pkg::word_t     trace_pc;
    rf_trace_pkg::seq_t      trace_seq;

    vec_t vecs[$];
    rec_t exp_q[$];
    int   errors = 0;
    int   seen = 0;
    int   exp_seq = 0;
    int   cyc = 0;
    int   total_cycles = 0;
    int   total_recs = 0;   // from the recs column
    bit   loaded = 1'b0;

    rf_trace_top dut_i
    (
        .clk         (clk),
        .reset       (reset),
        .wb1_wen     (wb1_wen),
        .wb0_wen     (wb0_wen),
        .wb1_wa      (wb1_wa),
        .wb0_wa      (wb0_wa),
        .wb1_wd      (wb1_wd),
        .wb0_wd      (wb0_wd),
        .wb1_pc      (wb1_pc),
        .wb0_pc      (wb0_pc),
        .trace_valid (trace_valid),
        .trace_reg   (trace_reg),
        .trace_data  (trace_data),
        .trace_pc    (trace_pc),
        .trace_seq   (trace_seq)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        int          rep;
        int          recs;
        string       line;
        logic [31:0] w1, a1, d1, p1, w0, a0, d0, p0;
        vec_t        v;
        ok = 1'b0;
        fd = $fopen("tb/rf_trace_vectors.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.substr(0, 0) != "#")
                begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %d",
                                rep, w1, a1, d1, p1, w0, a0, d0, p0, recs);
                    if (n == 10)
                    begin
                        v.rep  = rep;
                        v.wen1 = w1[0];
                        v.wa1  = a1[4:0];
                        v.wd1  = d1;
                        v.pc1  = p1;
                        v.wen0 = w0[0];
                        v.wa0  = a0[4:0];
                        v.wd0  = d0;
                        v.pc0  = p0;
                        vecs.push_back(v);
                        total_cycles += rep;
                        total_recs   += rep * recs;
                    end
                    else if (n > 0)
                    begin
                        $display("malformed vector line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    task automatic idle_inputs();
        wb1_wen = 1'b0;
        wb0_wen = 1'b0;
        wb1_wa  = '0;
        wb0_wa  = '0;
        wb1_wd  = '0;
        wb0_wd  = '0;
        wb1_pc  = '0;
        wb0_pc  = '0;
    endtask

    // expected records follow the MIPS rules: r0 dropped, lane 1 is older
    task automatic expect_writes();
        rec_t r;
        bit   k1;
        bit   k0;
        k1 = wb1_wen && (wb1_wa != 0);
        k0 = wb0_wen && (wb0_wa != 0);
        r.drive_cyc = cyc;
        r.exact     = (exp_q.size() == 0) && (k1 != k0);
        if (k1)
        begin
            r.wa = wb1_wa;
            r.wd = wb1_wd;
            r.pc = wb1_pc;
            exp_q.push_back(r);
        end
        if (k0)
        begin
            r.wa = wb0_wa;
            r.wd = wb0_wd;
            r.pc = wb0_pc;
            exp_q.push_back(r);
        end
    endtask

    task automatic apply_line(input vec_t v);
        for (int i = 0; i < v.rep; i++)
        begin
            @(posedge clk);
            #1;
            wb1_wen = v.wen1;
            wb1_wa  = v.wa1;
            wb1_wd  = v.wd1 + rf_trace_pkg::word_t'(i);
            wb1_pc  = v.pc1 + rf_trace_pkg::word_t'(8 * i);
            wb0_wen = v.wen0;
            wb0_wa  = v.wa0;
            wb0_wd  = v.wd0 + rf_trace_pkg::word_t'(i);
            wb0_pc  = v.pc0 + rf_trace_pkg::word_t'(8 * i);
            expect_writes();
        end
    endtask

    // outputs are settled half a cycle after the edge
    always @(negedge clk)
    begin
        rec_t r;
        if (!reset)
        begin
            if (trace_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("trace record for reg %0d came out with no write pending", trace_reg);
                    errors++;
                end
                else
                begin
                    r = exp_q.pop_front();
                    check("trace_reg", trace_reg, r.wa);
                    check("trace_data", trace_data, r.wd);
                    check("trace_pc", trace_pc, r.pc);
                    check("trace_seq", trace_seq, rf_trace_pkg::seq_t'(exp_seq));
                    if (r.exact)
                        check("latency", cyc - r.drive_cyc - 1, 3);   // cycles after sampling
                end
                seen++;
                exp_seq++;
            end
            else
            begin
                check("trace_reg", trace_reg, 0);
                check("trace_data", trace_data, 0);
                check("trace_pc", trace_pc, 0);
                check("trace_seq", trace_seq, 0);
            end
        end
    end

    initial
    begin
        bit ok;
        reset = 1'b1;
        idle_inputs();
        load_vectors(ok);
        if (!ok)
        begin
            $display("could not open tb/rf_trace_vectors.txt");
            $display("SIMULATION FAILED");
            $finish;
        end
        else
        begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            #1 reset = 1'b0;
            foreach (vecs[j])
                apply_line(vecs[j]);
            @(posedge clk);
            #1;
            idle_inputs();
            while (exp_q.size() != 0)
                @(posedge clk);
            repeat (6) @(posedge clk);   // catch stray records
            check("record_count", seen, total_recs);
            $display("errors: %0d, records: %0d of %0d", errors, seen, total_recs);
            if (errors == 0)
                $display("SIMULATION PASSED");
            else
                $display("SIMULATION FAILED");
            $finish;
        end
    end

    // watchdog, sized from the vector length plus a full queue drain
    initial
    begin
        int limit;
        wait (loaded);
        limit = total_cycles + rf_trace_pkg::QUEUE_DEPTH + 20 + 2;
        #(limit * 10);
        $display("timeout after %0d cycles, %0d records never appeared", limit, exp_q.size());
        foreach (exp_q[k])
            $display("missing record reg %0d data %h pc %h", exp_q[k].wa, exp_q[k].wd, exp_q[k].pc);
        errors++;
        $display("errors: %0d, records: %0d of %0d", errors, seen, total_recs);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* hw/rf_trace_top.sv */
module rf_trace_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb1_wen,
    input  logic                    wb0_wen,
    input  rf_trace_pkg::reg_addr_t wb1_wa,
    input  rf_trace_pkg::reg_addr_t wb0_wa,
    input  rf_trace_pkg::word_t     wb1_wd,
    input  rf_trace_pkg::word_t     wb0_wd,
    input  rf_trace_pkg::word_t     wb1_pc,
    input  rf_trace_pkg::word_t     wb0_pc,
    output logic                    trace_valid,
    output rf_trace_pkg::reg_addr_t trace_reg,
    output rf_trace_pkg::word_t     trace_data,
    output rf_trace_pkg::word_t     trace_pc,
    output rf_trace_pkg::seq_t      trace_seq
);

    rf_write_if lane1_w ();
    rf_write_if lane0_w ();
    rf_write_if head_w ();   // queue head towards the packer

    wb_lane_merge u_merge
    (
        .clk     (clk),
        .reset   (reset),
        .wb1_wen (wb1_wen),
        .wb0_wen (wb0_wen),
        .wb1_wa  (wb1_wa),
        .wb0_wa  (wb0_wa),
        .wb1_wd  (wb1_wd),
        .wb0_wd  (wb0_wd),
        .wb1_pc  (wb1_pc),
        .wb0_pc  (wb0_pc),
        .lane1   (lane1_w.src),
        .lane0   (lane0_w.src)
    );

    rfwrite_queue u_queue
    (
        .clk   (clk),
        .reset (reset),
        .lane1 (lane1_w.dst),
        .lane0 (lane0_w.dst),
        .head  (head_w.src)
    );

    trace_packer u_packer
    (
        .clk         (clk),
        .reset       (reset),
        .head        (head_w.dst),
        .trace_valid (trace_valid),
        .trace_reg   (trace_reg),
        .trace_data  (trace_data),
        .trace_pc    (trace_pc),
        .trace_seq   (trace_seq)
    );

endmodule

/* hw/trace_packer.sv */
module trace_packer
(
    input  logic                    clk,
    input  logic                    reset,
    rf_write_if.dst                 head,
    output logic                    trace_valid,
    output rf_trace_pkg::reg_addr_t trace_reg,
    output rf_trace_pkg::word_t     trace_data,
    output rf_trace_pkg::word_t     trace_pc,
    output rf_trace_pkg::seq_t      trace_seq
);

    rf_trace_pkg::seq_t seq_cnt;   // number of the next record

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            seq_cnt <= '0;
        else if (head.wen)
            seq_cnt <= seq_cnt + rf_trace_pkg::seq_t'(1);   // wraps at 16 bits
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            trace_valid <= 1'b0;
            trace_reg   <= '0;
            trace_data  <= '0;
            trace_pc    <= '0;
            trace_seq   <= '0;
        end
        else if (head.wen)
        begin
            trace_valid <= 1'b1;
            trace_reg   <= head.wa;
            trace_data  <= head.wd;
            trace_pc    <= head.pc;
            trace_seq   <= seq_cnt;
        end
        else
        begin
            // bus reads as zero in idle cycles
            trace_valid <= 1'b0;
            trace_reg   <= '0;
            trace_data  <= '0;
            trace_pc    <= '0;
            trace_seq   <= '0;
        end
    end

endmodule

/* hw/rfwrite_queue.sv */
module rfwrite_queue
(
    input  logic    clk,
    input  logic    reset,
    rf_write_if.dst lane1,
    rf_write_if.dst lane0,
    rf_write_if.src head
);

    rf_trace_pkg::qptr_t head_ptr;
    rf_trace_pkg::qptr_t tail_ptr;
    rf_trace_pkg::qptr_t tail_p1;
    rf_trace_pkg::qptr_t lane0_slot;

    logic [rf_trace_pkg::QUEUE_DEPTH-1:0] occ;   // one bit per entry

    rf_trace_pkg::reg_addr_t wa_mem [rf_trace_pkg::QUEUE_DEPTH];
    rf_trace_pkg::word_t     wd_mem [rf_trace_pkg::QUEUE_DEPTH];
    rf_trace_pkg::word_t     pc_mem [rf_trace_pkg::QUEUE_DEPTH];

    logic release_head;

    assign tail_p1 = tail_ptr + rf_trace_pkg::qptr_t'(1);

    // lane 1 is older, so lane 0 goes behind it when both write
    assign lane0_slot = lane1.wen ? tail_p1 : tail_ptr;

    assign release_head = occ[head_ptr];

    always_ff @(posedge clk)
    begin
        if (lane1.wen)
        begin
            wa_mem[tail_ptr] <= lane1.wa;
            wd_mem[tail_ptr] <= lane1.wd;
            pc_mem[tail_ptr] <= lane1.pc;
        end
        if (lane0.wen)
        begin
            wa_mem[lane0_slot] <= lane0.wa;
            wd_mem[lane0_slot] <= lane0.wd;
            pc_mem[lane0_slot] <= lane0.pc;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            occ      <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end
        else
        begin
            if (release_head)
            begin
                occ[head_ptr] <= 1'b0;
                head_ptr      <= head_ptr + rf_trace_pkg::qptr_t'(1);
            end
            if (lane1.wen)
                occ[tail_ptr] <= 1'b1;
            if (lane0.wen)
                occ[lane0_slot] <= 1'b1;
            tail_ptr <= tail_ptr + rf_trace_pkg::qptr_t'(lane1.wen)
                                 + rf_trace_pkg::qptr_t'(lane0.wen);   // 0, 1 or 2
        end
    end

    // head output register, zeroed whenever nothing is released
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            head.wen <= 1'b0;
            head.wa  <= '0;
            head.wd  <= '0;
            head.pc  <= '0;
        end
        else if (release_head)
        begin
            head.wen <= 1'b1;
            head.wa  <= wa_mem[head_ptr];
            head.wd  <= wd_mem[head_ptr];
            head.pc  <= pc_mem[head_ptr];
        end
        else
        begin
            head.wen <= 1'b0;
            head.wa  <= '0;
            head.wd  <= '0;
            head.pc  <= '0;
        end
    end

    // no back-pressure upstream, an append onto a live entry loses data
    no_overflow_l1: assert property (@(posedge clk) disable iff (reset)
        lane1.wen |-> !occ[tail_ptr])
        else $error("trace queue overflow on lane1 at slot %0d", tail_ptr);

    no_overflow_l0: assert property (@(posedge clk) disable iff (reset)
        lane0.wen |-> !occ[lane0_slot])
        else $error("trace queue overflow on lane0 at slot %0d", lane0_slot);

    // an empty queue has head caught up with tail
    empty_ptrs: assert property (@(posedge clk) disable iff (reset)
        (occ == '0) |-> (head_ptr == tail_ptr))
        else $error("queue empty but head %0d != tail %0d", head_ptr, tail_ptr);

endmodule

/* hw/wb_lane_merge.sv */
module wb_lane_merge
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb1_wen,
    input  logic                    wb0_wen,
    input  rf_trace_pkg::reg_addr_t wb1_wa,
    input  rf_trace_pkg::reg_addr_t wb0_wa,
    input  rf_trace_pkg::word_t     wb1_wd,
    input  rf_trace_pkg::word_t     wb0_wd,
    input  rf_trace_pkg::word_t     wb1_pc,
    input  rf_trace_pkg::word_t     wb0_pc,
    rf_write_if.src                 lane1,
    rf_write_if.src                 lane0
);

    logic wb1_keep;
    logic wb0_keep;

    // writes to r0 never change state, drop them here
    assign wb1_keep = wb1_wen && (wb1_wa != '0);
    assign wb0_keep = wb0_wen && (wb0_wa != '0);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            lane1.wen <= 1'b0;
            lane0.wen <= 1'b0;
        end
        else
        begin
            lane1.wen <= wb1_keep;
            lane0.wen <= wb0_keep;
        end
    end

    // payload follows the strobe, no reset needed
    always_ff @(posedge clk)
    begin
        lane1.wa <= wb1_wa;
        lane1.wd <= wb1_wd;
        lane1.pc <= wb1_pc;
        lane0.wa <= wb0_wa;
        lane0.wd <= wb0_wd;
        lane0.pc <= wb0_pc;
    end

    // the queue must only ever see real writes
    lane1_no_r0: assert property (@(posedge clk) disable iff (reset)
        lane1.wen |-> (lane1.wa != '0))
        else $error("lane1 forwarded a write to r0");

    lane0_no_r0: assert property (@(posedge clk) disable iff (reset)
        lane0.wen |-> (lane0.wa != '0))
        else $error("lane0 forwarded a write to r0");

endmodule

/* hw/rf_write_if.sv */
// one register-file write, no handshake: wen high means take it this cycle
interface rf_write_if;

    logic                   wen;
    rf_trace_pkg::reg_addr_t wa;
    rf_trace_pkg::word_t     wd;
    rf_trace_pkg::word_t     pc;   // pc of the retiring instruction

    modport src
    (
        output wen,
        output wa,
        output wd,
        output pc
    );

    modport dst
    (
        input wen,
        input wa,
        input wd,
        input pc
    );

endinterface

/* hw/rf_trace_pkg.sv */
package rf_trace_pkg;

    // basic widths
    localparam int WORD_W = 32;
    localparam int REG_AW = 5;
    localparam int SEQ_W  = 16;

    // trace queue geometry
    localparam int QUEUE_DEPTH = 64;
    localparam int QUEUE_AW    = 6;   // log2 of QUEUE_DEPTH

    // data word or instruction address
    typedef logic [WORD_W-1:0] word_t;

    // architectural register number, r0 is hardwired to zero
    typedef logic [REG_AW-1:0] reg_addr_t;

    // record number stamped by the packer, wraps
    typedef logic [SEQ_W-1:0] seq_t;

    // queue index, wraps naturally at QUEUE_DEPTH
    typedef logic [QUEUE_AW-1:0] qptr_t;

endpackage
